//--- otp_scrmbl.f
+incdir+.
otp_scrmbl_pkg.sv
present_enc_round.sv
present_dec_round.sv
scrmbl_key_lut.sv
scrmbl_ctrl.sv
otp_scrmbl.sv
tb_clk_gen.sv
tb_otp_scrmbl.sv

//--- otp_scrmbl.sv
/* top level of the PRESENT-128 scrambling engine: working register,
   next-state muxes, control FSM, key table and round instances */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module otp_scrmbl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  otp_scrmbl_pkg::scrmbl_req_t     req_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  output logic [`OTP_SCRMBL_BLOCK_W-1:0]  data_o,
  output logic                            valid_o
);

  import otp_scrmbl_pkg::*;

  localparam int KEY_W = `OTP_SCRMBL_KEY_W;
  // encryption walks the index up from 1, decryption down from the round count
  localparam round_idx_t ENC_START_IDX = round_idx_t'(1);
  localparam round_idx_t DEC_START_IDX = round_idx_t'(`OTP_SCRMBL_NUM_ROUNDS);

  logic         load;
  logic         decrypt;
  logic         round_en;
  logic         done;
  logic [KEY_W-1:0] enc_key;
  logic [KEY_W-1:0] dec_key;
  round_state_t state_d;
  round_state_t state_q;
  round_state_t load_state;
  round_state_t enc_state;
  round_state_t dec_state;

  ////////////////////
  // control
  ////////////////////

  scrmbl_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_i),
    .cmd_i      (req_i.cmd),
    .ready_o    (ready_o),
    .load_o     (load),
    .decrypt_o  (decrypt),
    .round_en_o (round_en),
    .done_o     (done)
  );

  // key for the selector on the request, only sampled on load
  scrmbl_key_lut u_key_lut (
    .sel_i     (req_i.sel),
    .enc_key_o (enc_key),
    .dec_key_o (dec_key)
  );

  ////////////////////
  // data path
  ////////////////////

  // both directions look at the same register, ctrl picks the result
  present_enc_round u_enc_round (
    .state_i (state_q),
    .state_o (enc_state)
  );

  present_dec_round u_dec_round (
    .state_i (state_q),
    .state_o (dec_state)
  );

  // initial state for a new command
  assign load_state.data = req_i.data;
  assign load_state.key  = decrypt ? dec_key : enc_key;
  assign load_state.idx  = decrypt ? DEC_START_IDX : ENC_START_IDX;

  always_comb begin : p_next_state
    state_d = state_q;
    if (load) begin
      state_d = load_state;
    end else if (round_en) begin
      state_d = decrypt ? dec_state : enc_state;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_reg
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  // result only visible during the done pulse
  assign valid_o = done;
  assign data_o  = done ? state_q.data : '0;

endmodule

//--- otp_scrmbl_cfg.svh
/* round count, block and key widths, number of key slots
   and the fixed key table of the scrambling engine */

`ifndef OTP_SCRMBL_CFG_SVH
`define OTP_SCRMBL_CFG_SVH

// number of PRESENT rounds, the final whitening is folded into the last one
`define OTP_SCRMBL_NUM_ROUNDS 31

// data block and key widths of PRESENT-128
`define OTP_SCRMBL_BLOCK_W 64
`define OTP_SCRMBL_KEY_W 128

// key slots selectable with sel
`define OTP_SCRMBL_NUM_KEYS 4

////////////////////
// key table
////////////////////

// slot 0 is the all-zero key, handy for the published test vector
`define OTP_SCRMBL_KEY0 128'h00000000_00000000_00000000_00000000
`define OTP_SCRMBL_KEY1 128'h3ba1c07e_5d92f4a8_6e01b7c3_94d28f5a
`define OTP_SCRMBL_KEY2 128'hc4f17a20_9e3b58d6_0b7d1e94_a25c6f83
`define OTP_SCRMBL_KEY3 128'h71e9d34b_a06c2f58_e83a95c1_4f0b7d26

`endif

//--- otp_scrmbl_pkg.sv
/* command, request and round-state types of the scrambling engine,
   the PRESENT S-box table and the forward key-schedule step */

`include "otp_scrmbl_cfg.svh"

package otp_scrmbl_pkg;

  ////////////////////
  // types
  ////////////////////

  // only these two codes start an operation, anything else is dropped
  typedef enum logic [1:0] {
    cmd_encrypt = 2'b01,
    cmd_decrypt = 2'b10
  } scrmbl_cmd_e;

  // round index, must hold the round count itself
  typedef logic [$clog2(`OTP_SCRMBL_NUM_ROUNDS + 1)-1:0] round_idx_t;

  // one command as seen on the input port
  typedef struct packed {
    scrmbl_cmd_e                              cmd;
    logic [$clog2(`OTP_SCRMBL_NUM_KEYS)-1:0] sel;
    logic [`OTP_SCRMBL_BLOCK_W-1:0]           data;
  } scrmbl_req_t;

  // working state carried from round to round
  typedef struct packed {
    logic [`OTP_SCRMBL_BLOCK_W-1:0] data;
    logic [`OTP_SCRMBL_KEY_W-1:0]   key;
    round_idx_t                     idx;
  } round_state_t;

  ////////////////////
  // cipher helpers
  ////////////////////

  // PRESENT 4-bit S-box, nibble n holds S(n)
  localparam logic [15:0][3:0] PRESENT_SBOX = 64'h2174_8fe3_da09_b65c;

  // one forward step of the 128-bit key schedule
  function automatic logic [`OTP_SCRMBL_KEY_W-1:0] present_fwd_key_step(
    input logic [`OTP_SCRMBL_KEY_W-1:0] key,
    input round_idx_t                   idx
  );
    logic [`OTP_SCRMBL_KEY_W-1:0] k;
    // rotate left by 61
    k = {key[66:0], key[127:67]};
    // the two top nibbles go through the S-box
    k[127:124] = PRESENT_SBOX[k[127:124]];
    k[123:120] = PRESENT_SBOX[k[123:120]];
    // round counter mixed into bits 66..62
    k[66:62] = k[66:62] ^ idx;
    return k;
  endfunction

endpackage

//--- present_dec_round.sv
/* one PRESENT-128 decryption round with the inverse key-schedule step,
   removes the output whitening on the first decrypt round */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module present_dec_round (
  input  otp_scrmbl_pkg::round_state_t state_i,
  output otp_scrmbl_pkg::round_state_t state_o
);

  import otp_scrmbl_pkg::*;

  localparam int BLOCK_W = `OTP_SCRMBL_BLOCK_W;
  localparam int KEY_W   = `OTP_SCRMBL_KEY_W;
  // first decrypt round carries the highest index
  localparam round_idx_t FIRST_IDX = round_idx_t'(`OTP_SCRMBL_NUM_ROUNDS);

  // inverse S-box, nibble n holds S^-1(n)
  localparam logic [15:0][3:0] PRESENT_INV_SBOX = 64'ha970_364b_d21c_8fe5;

  // undoes present_fwd_key_step for the same index
  function automatic logic [KEY_W-1:0] inv_key_step(
    input logic [KEY_W-1:0] key,
    input round_idx_t       idx
  );
    logic [KEY_W-1:0] k;
    k = key;
    k[66:62]   = k[66:62] ^ idx;
    k[127:124] = PRESENT_INV_SBOX[k[127:124]];
    k[123:120] = PRESENT_INV_SBOX[k[123:120]];
    // rotate right by 61
    return {k[60:0], k[127:61]};
  endfunction

  logic [BLOCK_W-1:0] data_in;
  logic [BLOCK_W-1:0] perm_out;
  logic [BLOCK_W-1:0] sbox_out;
  logic [KEY_W-1:0]   prev_key;

  // strip the whitening key before the first inverse round
  assign data_in = (state_i.idx == FIRST_IDX) ?
                   (state_i.data ^ state_i.key[KEY_W-1 -: BLOCK_W]) : state_i.data;

  // inverse permutation, bit i is fetched from 16*i mod 63
  always_comb begin : p_inv_perm
    perm_out[BLOCK_W-1] = data_in[BLOCK_W-1];
    for (int i = 0; i < BLOCK_W - 1; i++) begin
      perm_out[i] = data_in[(i * (BLOCK_W / 4)) % (BLOCK_W - 1)];
    end
  end

  // inverse substitution on every nibble
  always_comb begin : p_inv_sbox
    for (int n = 0; n < BLOCK_W / 4; n++) begin
      sbox_out[4*n +: 4] = PRESENT_INV_SBOX[perm_out[4*n +: 4]];
    end
  end

  ////////////////////
  // key schedule
  ////////////////////

  // step back to the key this round was entered with on encryption
  assign prev_key = inv_key_step(state_i.key, state_i.idx);

  assign state_o.data = sbox_out ^ prev_key[KEY_W-1 -: BLOCK_W];
  assign state_o.key  = prev_key;
  // reaches zero after the last decrypt round
  assign state_o.idx  = state_i.idx - round_idx_t'(1);

endmodule

//--- present_enc_round.sv
/* one PRESENT-128 encryption round with its key-schedule step
   and the final whitening on the last round */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module present_enc_round (
  input  otp_scrmbl_pkg::round_state_t state_i,
  output otp_scrmbl_pkg::round_state_t state_o
);

  import otp_scrmbl_pkg::*;

  localparam int BLOCK_W = `OTP_SCRMBL_BLOCK_W;
  localparam int KEY_W   = `OTP_SCRMBL_KEY_W;
  // last round index, also triggers the output whitening
  localparam round_idx_t LAST_IDX = round_idx_t'(`OTP_SCRMBL_NUM_ROUNDS);

  logic [BLOCK_W-1:0] key_add;
  logic [BLOCK_W-1:0] sbox_out;
  logic [BLOCK_W-1:0] perm_out;
  logic [KEY_W-1:0]   next_key;
  logic               last_round;

  ////////////////////
  // data path
  ////////////////////

  // round key is the upper half of the key register
  assign key_add = state_i.data ^ state_i.key[KEY_W-1 -: BLOCK_W];

  // substitution layer over all sixteen nibbles
  always_comb begin : p_sbox
    for (int n = 0; n < BLOCK_W / 4; n++) begin
      sbox_out[4*n +: 4] = PRESENT_SBOX[key_add[4*n +: 4]];
    end
  end

  // bit permutation, bit i goes to 16*i mod 63
  // the top bit stays where it is
  always_comb begin : p_perm
    perm_out[BLOCK_W-1] = sbox_out[BLOCK_W-1];
    for (int i = 0; i < BLOCK_W - 1; i++) begin
      perm_out[(i * (BLOCK_W / 4)) % (BLOCK_W - 1)] = sbox_out[i];
    end
  end

  ////////////////////
  // key schedule
  ////////////////////

  assign next_key   = present_fwd_key_step(state_i.key, state_i.idx);
  assign last_round = (state_i.idx == LAST_IDX);

  // the last round also adds the 32nd round key, so ciphertext comes out
  assign state_o.data = last_round ? (perm_out ^ next_key[KEY_W-1 -: BLOCK_W]) : perm_out;
  assign state_o.key  = next_key;
  // wraps to zero after the last round
  assign state_o.idx  = state_i.idx + round_idx_t'(1);

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_otp_scrmbl \
  -f otp_scrmbl.f -o sim_tb_otp_scrmbl \
  && ./obj_dir/sim_tb_otp_scrmbl | grep -x "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- scrmbl_ctrl.sv
/* command decode FSM and round counter of the scrambling engine */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module scrmbl_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        valid_i,
  input  otp_scrmbl_pkg::scrmbl_cmd_e cmd_i,
  output logic                        ready_o,
  output logic                        load_o,
  output logic                        decrypt_o,
  output logic                        round_en_o,
  output logic                        done_o
);

  import otp_scrmbl_pkg::*;

  localparam int CNT_W = $clog2(`OTP_SCRMBL_NUM_ROUNDS + 1);
  // rounds run at counts 0..30, count 31 is the drain cycle
  localparam logic [CNT_W-1:0] FINISH_CNT = CNT_W'(`OTP_SCRMBL_NUM_ROUNDS);
  // cycles spent outside idle per command
  localparam int BUSY_CYCLES = `OTP_SCRMBL_NUM_ROUNDS + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_encrypt,
    st_decrypt
  } state_e;

  state_e           state_d;
  state_e           state_q;
  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] cnt_q;
  logic             done_d;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    cnt_d      = cnt_q;
    ready_o    = 1'b0;
    load_o     = 1'b0;
    decrypt_o  = 1'b0;
    round_en_o = 1'b0;
    done_d     = 1'b0;

    unique case (state_q)
      // wait for a command, the working register loads on acceptance
      st_idle: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          case (cmd_i)
            cmd_encrypt: begin
              load_o  = 1'b1;
              state_d = st_encrypt;
            end
            cmd_decrypt: begin
              load_o    = 1'b1;
              decrypt_o = 1'b1;
              state_d   = st_decrypt;
            end
            // undefined codes are dropped, stay ready
            default: begin
              state_d = st_idle;
            end
          endcase
        end
      end
      // one round per cycle, then one drain cycle before done
      st_encrypt, st_decrypt: begin
        decrypt_o  = (state_q == st_decrypt);
        round_en_o = (cnt_q != FINISH_CNT);
        cnt_d      = cnt_q + CNT_W'(1);
        if (cnt_q == FINISH_CNT) begin
          state_d = st_idle;
          done_d  = 1'b1;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_o  <= done_d;
    end
  end

  // every done pulse belongs to a load a fixed number of cycles back
  a_done_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> $past(load_o, BUSY_CYCLES + 1));

endmodule

//--- scrmbl_key_lut.sv
/* encryption key table and the matching decryption key table,
   both indexed by the key selector */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module scrmbl_key_lut (
  input  logic [$clog2(`OTP_SCRMBL_NUM_KEYS)-1:0] sel_i,
  output logic [`OTP_SCRMBL_KEY_W-1:0]            enc_key_o,
  output logic [`OTP_SCRMBL_KEY_W-1:0]            dec_key_o
);

  import otp_scrmbl_pkg::*;

  localparam int NUM_KEYS   = `OTP_SCRMBL_NUM_KEYS;
  localparam int KEY_W      = `OTP_SCRMBL_KEY_W;
  localparam int NUM_ROUNDS = `OTP_SCRMBL_NUM_ROUNDS;

  typedef logic [NUM_KEYS-1:0][KEY_W-1:0] key_tbl_t;

  // decryption starts from the last round key, i.e. the key stepped forward
  // through the whole schedule
  function automatic key_tbl_t calc_dec_keys(input key_tbl_t enc_keys);
    key_tbl_t dec_keys;
    dec_keys = enc_keys;
    for (int k = 0; k < NUM_KEYS; k++) begin
      for (int r = 1; r <= NUM_ROUNDS; r++) begin
        dec_keys[k] = present_fwd_key_step(dec_keys[k], round_idx_t'(r));
      end
    end
    return dec_keys;
  endfunction

  // slot 0 sits in the lowest entry
  localparam key_tbl_t ENC_KEYS = {`OTP_SCRMBL_KEY3, `OTP_SCRMBL_KEY2,
                                   `OTP_SCRMBL_KEY1, `OTP_SCRMBL_KEY0};
  // resolved at elaboration, no schedule logic in hardware
  localparam key_tbl_t DEC_KEYS = calc_dec_keys(ENC_KEYS);

  assign enc_key_o = ENC_KEYS[sel_i];
  assign dec_key_o = DEC_KEYS[sel_i];

endmodule

//--- tb_clk_gen.sv
/* testbench clock and reset generator */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, 10 ns period with the defaults
  initial begin : p_clk
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held for a few rising edges, released away from the active edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_otp_scrmbl.sv
/* testbench of the scrambling engine: stimulus, random blocks from an LFSR,
   reference model of the handshake, assertions and watchdog */

`timescale 1ns/1ps

`include "otp_scrmbl_cfg.svh"

module tb_otp_scrmbl;

  import otp_scrmbl_pkg::*;

  localparam int BLOCK_W  = `OTP_SCRMBL_BLOCK_W;
  localparam int NUM_KEYS = `OTP_SCRMBL_NUM_KEYS;
  // edges from acceptance to the edge that samples valid_o high
  localparam logic [5:0] DONE_CNT = 6'(`OTP_SCRMBL_NUM_ROUNDS + 2);
  // known answer, four commands per key slot, two undefined codes
  localparam int NUM_CMDS        = 1 + 4 * NUM_KEYS + 2;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + 100;
  localparam int RESULT_TIMEOUT  = 40;
  localparam int BUSY_HOLD       = 5;
  localparam logic [31:0] LFSR_SEED = 32'h5994_43c9;
  // PRESENT-128, zero key and zero plaintext
  localparam logic [BLOCK_W-1:0] KAT_CIPHER = 64'h96db_702a_2e69_00af;

  logic               clk_i;
  logic               rst_ni;
  scrmbl_req_t        req_i;
  logic               valid_i;
  logic               ready_o;
  logic [BLOCK_W-1:0] data_o;
  logic               valid_o;

  logic [31:0]        lfsr_q;
  logic               accept;
  logic [5:0]         busy_cnt;
  logic               exp_ready;
  logic               exp_check;
  logic [BLOCK_W-1:0] exp_data;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  otp_scrmbl UUT (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  ////////////////////
  // handshake model
  ////////////////////

  // only the two defined codes start an operation, and only while idle
  assign accept    = valid_i && exp_ready && (req_i.cmd inside {cmd_encrypt, cmd_decrypt});
  assign exp_ready = (busy_cnt == '0) || (busy_cnt == DONE_CNT);

  // counts edges since the accepting edge, 0 when idle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_busy_model
    if (!rst_ni) begin
      busy_cnt <= '0;
    end else if (accept) begin
      busy_cnt <= 6'd1;
    end else if (busy_cnt != '0 && busy_cnt < DONE_CNT) begin
      busy_cnt <= busy_cnt + 6'd1;
    end else begin
      busy_cnt <= '0;
    end
  end

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  ////////////////////
  // assertions
  ////////////////////

  a_reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> ready_o && !valid_o && data_o == '0)
    else begin
      $display("ERROR %0t: after reset ready_o/valid_o/data_o expected 1/0/%h, got %b/%b/%h",
               $time, 64'h0, $sampled(ready_o), $sampled(valid_o), $sampled(data_o));
      stop_with_failure();
    end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni) ready_o == exp_ready)
    else begin
      $display("ERROR %0t: ready_o expected %b, got %b",
               $time, $sampled(exp_ready), $sampled(ready_o));
      stop_with_failure();
    end

  // one pulse per accepted command, at the fixed latency
  a_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o == (busy_cnt == DONE_CNT))
    else begin
      $display("ERROR %0t: valid_o expected %b, got %b",
               $time, $sampled(busy_cnt == DONE_CNT), $sampled(valid_o));
      stop_with_failure();
    end

  a_data_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_o |-> data_o == '0)
    else begin
      $display("ERROR %0t: data_o expected %h, got %h", $time, 64'h0, $sampled(data_o));
      stop_with_failure();
    end

  a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && exp_check |-> data_o == exp_data)
    else begin
      $display("ERROR %0t: data_o expected %h, got %h",
               $time, $sampled(exp_data), $sampled(data_o));
      stop_with_failure();
    end

  ////////////////////
  // stimulus helpers
  ////////////////////

  // Galois LFSR, stepped once for every bit taken
  task automatic random_block(output logic [BLOCK_W-1:0] blk);
    for (int b = 0; b < BLOCK_W; b++) begin
      blk[b] = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
  endtask

  // issue one command, then hold a conflicting request while busy
  task automatic run_cmd(input scrmbl_cmd_e cmd, input logic [1:0] sel,
                         input logic [BLOCK_W-1:0] data, input logic check,
                         input logic [BLOCK_W-1:0] expected,
                         output logic [BLOCK_W-1:0] blk);
    int cycles;
    exp_check = check;
    exp_data  = expected;
    req_i     = '{cmd: cmd, sel: sel, data: data};
    valid_i   = 1'b1;
    @(negedge clk_i);
    req_i = '{cmd: (cmd == cmd_encrypt) ? cmd_decrypt : cmd_encrypt, sel: ~sel, data: ~data};
    repeat (BUSY_HOLD) @(negedge clk_i);
    valid_i = 1'b0;
    cycles  = 0;
    while (!valid_o && cycles < RESULT_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!valid_o) begin
      $display("no valid_o pulse within %0d cycles of a command", RESULT_TIMEOUT);
      stop_with_failure();
    end
    blk = data_o;
    // let the result edge pass before the expectation changes
    @(negedge clk_i);
  endtask

  // undefined code for one cycle, then long enough for a stray pulse to show
  task automatic send_undefined(input logic [1:0] code);
    req_i   = '{cmd: scrmbl_cmd_e'(code), sel: code, data: {BLOCK_W{1'b1}}};
    valid_i = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    repeat (int'(DONE_CNT) + 2) @(negedge clk_i);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : p_stimulus
    logic [BLOCK_W-1:0] blk_a;
    logic [BLOCK_W-1:0] blk_b;
    logic [BLOCK_W-1:0] ct_a;
    logic [BLOCK_W-1:0] ct_b;
    logic [BLOCK_W-1:0] pt;
    lfsr_q    = LFSR_SEED;
    req_i     = '0;
    valid_i   = 1'b0;
    exp_check = 1'b0;
    exp_data  = '0;
    @(posedge rst_ni);
    @(negedge clk_i);
    // published vector, slot 0 holds the all-zero key
    run_cmd(cmd_encrypt, 2'd0, '0, 1'b1, KAT_CIPHER, ct_a);
    for (int s = 0; s < NUM_KEYS; s++) begin
      random_block(blk_a);
      random_block(blk_b);
      if (blk_b == blk_a) begin
        blk_b[0] = ~blk_b[0];
      end
      run_cmd(cmd_encrypt, 2'(s), blk_a, 1'b0, '0, ct_a);
      run_cmd(cmd_encrypt, 2'(s), blk_b, 1'b0, '0, ct_b);
      assert (ct_a != ct_b)
        else begin
          $display("two different blocks encrypted to the same value %h under key slot %0d",
                   ct_a, s);
          stop_with_failure();
        end
      // decryption has to give back the original blocks
      run_cmd(cmd_decrypt, 2'(s), ct_a, 1'b1, blk_a, pt);
      run_cmd(cmd_decrypt, 2'(s), ct_b, 1'b1, blk_b, pt);
    end
    send_undefined(2'b00);
    send_undefined(2'b11);
    $display("NO ERRORS");
    $finish;
  end

  // bound on the whole run, sized from the number of commands
  initial begin : p_watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    stop_with_failure();
  end

endmodule
